// File: logic/adder_ctrl_pkg.sv
package adder_ctrl_pkg;

    // operand_b sign is flipped for sub
    typedef enum logic {
        OP_ADD = 1'b0,
        OP_SUB = 1'b1
    } add_op_e;

    typedef enum logic {
        RUN_IDLE = 1'b0,    // waiting for start
        RUN_BUSY = 1'b1     // operation in flight
    } run_state_e;

endpackage

// File: logic/fp16_align.sv
`timescale 1ns/1ns
`include "fp16_consts.svh"

module fp16_align (
    input  fp16_pkg::fp16_t        operand_a,
    input  fp16_pkg::fp16_t        operand_b,
    input  adder_ctrl_pkg::add_op_e op,
    output logic                   sign_big,
    output logic                   sign_small,
    output fp16_pkg::align_frac_t  frac_big,
    output fp16_pkg::align_frac_t  frac_small,
    output fp16_pkg::exp_t         exp_max
);

    logic                  sign_a, sign_b;
    fp16_pkg::exp_t        exp_a, exp_b;
    fp16_pkg::align_frac_t sig_a, sig_b;
    logic                  a_is_big;
    fp16_pkg::exp_t        exp_small;
    fp16_pkg::exp_t        exp_diff;
    fp16_pkg::align_frac_t sig_small;

    // unpack fields
    assign sign_a = operand_a[`FP16_W-1];
    assign sign_b = operand_b[`FP16_W-1] ^ (op == adder_ctrl_pkg::OP_SUB); // sub flips b
    assign exp_a  = operand_a[`FP16_W-2 -: `FP16_EXP_W];
    assign exp_b  = operand_b[`FP16_W-2 -: `FP16_EXP_W];

    // exponent 0 is read as zero, no subnormals
    assign sig_a = (exp_a == '0) ? '0 :
                   {1'b1, operand_a[`FP16_MAN_W-1:0], {(`ALIGN_W-`FP16_MAN_W-1){1'b0}}};
    assign sig_b = (exp_b == '0) ? '0 :
                   {1'b1, operand_b[`FP16_MAN_W-1:0], {(`ALIGN_W-`FP16_MAN_W-1){1'b0}}};

    // order by exponent first, then by significand
    assign a_is_big = (exp_a > exp_b) || ((exp_a == exp_b) && (sig_a >= sig_b));

    assign sign_big   = a_is_big ? sign_a : sign_b;
    assign sign_small = a_is_big ? sign_b : sign_a;
    assign exp_max    = a_is_big ? exp_a : exp_b;
    assign exp_small  = a_is_big ? exp_b : exp_a;
    assign frac_big   = a_is_big ? sig_a : sig_b;
    assign sig_small  = a_is_big ? sig_b : sig_a;

    assign exp_diff = exp_max - exp_small;   // never negative

    // small operand drops out completely past the field width
    assign frac_small = (exp_diff >= `ALIGN_W) ? '0 : (sig_small >> exp_diff);

endmodule

// File: logic/fp16_consts.svh
`ifndef FP16_CONSTS_SVH
`define FP16_CONSTS_SVH

// word and field widths
`define FP16_W          16
`define FP16_EXP_W      5
`define FP16_MAN_W      10

// hidden bit + stored fraction + two alignment bits
`define ALIGN_W         13

// all-ones exponent, reserved for infinity
`define FP16_EXP_MAX    31

// OR the sign bit on top for negative infinity
`define FP16_POS_INF    16'h7C00

`endif

// File: logic/fp16_mantissa_add.sv
`timescale 1ns/1ns
`include "fp16_consts.svh"

module fp16_mantissa_add (
    input  logic                  sign_big,
    input  logic                  sign_small,
    input  fp16_pkg::align_frac_t frac_big,
    input  fp16_pkg::align_frac_t frac_small,
    input  fp16_pkg::exp_t        exp_max,
    output logic                  sum_sign,
    output fp16_pkg::align_frac_t sum_frac,
    output logic                  carry,
    output fp16_pkg::exp_t        sum_exp
);

    logic               same_sign;
    logic [`ALIGN_W:0]  sum_wide;    // one extra bit for the carry

    assign same_sign = (sign_big == sign_small);

    // big >= small is guaranteed by the align stage, so no borrow
    assign sum_wide = same_sign ? ({1'b0, frac_big} + {1'b0, frac_small})
                                : ({1'b0, frac_big} - {1'b0, frac_small});

    assign carry    = sum_wide[`ALIGN_W];
    assign sum_frac = sum_wide[`ALIGN_W-1:0];

    // exact cancellation gives +0
    assign sum_sign = (!same_sign && (sum_wide == '0)) ? 1'b0 : sign_big;

    assign sum_exp = exp_max;   // normalize adjusts it

endmodule

// File: logic/fp16_normalize.sv
`timescale 1ns/1ns
`include "fp16_consts.svh"

module fp16_normalize (
    input  logic                  sum_sign,
    input  fp16_pkg::align_frac_t sum_frac,
    input  logic                  carry,
    input  fp16_pkg::exp_t        sum_exp,
    output fp16_pkg::fp16_t       result,
    output logic                  overflow
);

    logic [3:0]              lz;            // leading zeros of sum_frac
    logic [`FP16_EXP_W:0]    exp_wide;      // extra bit catches the carry increment
    fp16_pkg::align_frac_t   frac_norm;
    logic                    is_zero;

    // highest set bit wins, loop runs upward
    always_comb begin : lead_zero
        lz = '0;
        for (int i = 0; i < `ALIGN_W; i++) begin
            if (sum_frac[i]) begin
                lz = 4'(`ALIGN_W - 1 - i);
            end
        end
    end

    always_comb begin : shift_norm
        is_zero = 1'b0;
        if (carry) begin
            // 14-bit sum, shift right once
            frac_norm = {1'b1, sum_frac[`ALIGN_W-1:1]};
            exp_wide  = {1'b0, sum_exp} + 1'b1;
        end else begin
            frac_norm = sum_frac << lz;
            exp_wide  = {1'b0, sum_exp} - {2'b00, lz};
            // zero sum or underflow, both flush to zero
            if ((sum_frac == '0) || ({1'b0, sum_exp} <= {2'b00, lz})) begin
                is_zero = 1'b1;
            end
        end
    end

    assign overflow = !is_zero && (exp_wide >= `FP16_EXP_MAX);

    always_comb begin : pack
        if (overflow) begin
            result = `FP16_POS_INF | {sum_sign, {(`FP16_W-1){1'b0}}};  // signed infinity
        end else if (is_zero) begin
            result = {sum_sign, {(`FP16_W-1){1'b0}}};
        end else begin
            // drop hidden bit, truncate the two alignment bits
            result = {sum_sign, exp_wide[`FP16_EXP_W-1:0],
                      frac_norm[`ALIGN_W-2 -: `FP16_MAN_W]};
        end
    end

endmodule

// File: logic/fp16_pkg.sv
`include "fp16_consts.svh"

package fp16_pkg;

    // full operand / result word
    typedef logic [`FP16_W-1:0] fp16_t;

    // biased exponent field
    typedef logic [`FP16_EXP_W-1:0] exp_t;

    // aligned significand, low two bits are cut off at the end
    typedef logic [`ALIGN_W-1:0] align_frac_t;

endpackage

// File: logic/sysarr_adder.sv
`timescale 1ns/1ns

module sysarr_adder (
    input  logic                    clk,
    input  logic                    nRST,
    input  logic                    start,
    input  adder_ctrl_pkg::add_op_e op,
    input  fp16_pkg::fp16_t         operand_a,
    input  fp16_pkg::fp16_t         operand_b,
    output logic                    value_ready,
    output fp16_pkg::fp16_t         result,
    output logic                    overflow
);

    adder_ctrl_pkg::run_state_e state;
    logic accept;
    logic run;
    logic token_1, token_2;     // start token, follows the data

    // align stage outputs
    logic                  al_sign_big, al_sign_small;
    fp16_pkg::align_frac_t al_frac_big, al_frac_small;
    fp16_pkg::exp_t        al_exp_max;

    // bank 1
    logic                  b1_sign_big, b1_sign_small;
    fp16_pkg::align_frac_t b1_frac_big, b1_frac_small;
    fp16_pkg::exp_t        b1_exp_max;

    // mantissa add outputs
    logic                  ad_sum_sign;
    fp16_pkg::align_frac_t ad_sum_frac;
    logic                  ad_carry;
    fp16_pkg::exp_t        ad_sum_exp;

    // bank 2
    logic                  b2_sum_sign;
    fp16_pkg::align_frac_t b2_sum_frac;
    logic                  b2_carry;
    fp16_pkg::exp_t        b2_sum_exp;

    // start only counts when idle
    assign accept      = start && (state == adder_ctrl_pkg::RUN_IDLE);
    assign run         = accept || (state == adder_ctrl_pkg::RUN_BUSY);
    assign value_ready = (state == adder_ctrl_pkg::RUN_IDLE) && !start;  // drops with start

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            state <= adder_ctrl_pkg::RUN_IDLE;
        end else if (accept) begin
            state <= adder_ctrl_pkg::RUN_BUSY;
        end else if (token_2) begin
            state <= adder_ctrl_pkg::RUN_IDLE;  // token reached bank 2 last edge
        end
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            token_1 <= 1'b0;
            token_2 <= 1'b0;
        end else if (run) begin
            token_1 <= accept;
            token_2 <= token_1;
        end
    end

    fp16_align u_align (
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .op         (op),
        .sign_big   (al_sign_big),
        .sign_small (al_sign_small),
        .frac_big   (al_frac_big),
        .frac_small (al_frac_small),
        .exp_max    (al_exp_max)
    );

    // bank 1 captures the operands only at the accepting edge
    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            b1_sign_big   <= 1'b0;
            b1_sign_small <= 1'b0;
            b1_frac_big   <= '0;
            b1_frac_small <= '0;
            b1_exp_max    <= '0;
        end else if (accept) begin
            b1_sign_big   <= al_sign_big;
            b1_sign_small <= al_sign_small;
            b1_frac_big   <= al_frac_big;
            b1_frac_small <= al_frac_small;
            b1_exp_max    <= al_exp_max;
        end
    end

    fp16_mantissa_add u_mant_add (
        .sign_big   (b1_sign_big),
        .sign_small (b1_sign_small),
        .frac_big   (b1_frac_big),
        .frac_small (b1_frac_small),
        .exp_max    (b1_exp_max),
        .sum_sign   (ad_sum_sign),
        .sum_frac   (ad_sum_frac),
        .carry      (ad_carry),
        .sum_exp    (ad_sum_exp)
    );

    // bank 2 loads when the token leaves bank 1
    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            b2_sum_sign <= 1'b0;
            b2_sum_frac <= '0;
            b2_carry    <= 1'b0;
            b2_sum_exp  <= '0;
        end else if (token_1) begin
            b2_sum_sign <= ad_sum_sign;
            b2_sum_frac <= ad_sum_frac;
            b2_carry    <= ad_carry;
            b2_sum_exp  <= ad_sum_exp;
        end
    end

    fp16_normalize u_normalize (
        .sum_sign (b2_sum_sign),
        .sum_frac (b2_sum_frac),
        .carry    (b2_carry),
        .sum_exp  (b2_sum_exp),
        .result   (result),
        .overflow (overflow)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

# build the testbench together with the bound checker
verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tb_sysarr_adder -Mdir obj_dir

# run and keep a log for the result search
./obj_dir/Vtb_sysarr_adder 2>&1 | tee sim.log

if grep -qx "test passed" sim.log; then
    echo "simulation PASSED"
    exit 0
else
    echo "simulation FAILED"
    exit 1
fi

// File: tb/sysarr_adder_checker.sv
`timescale 1ns/1ns

module sysarr_adder_checker (
    input logic                       clk,
    input logic                       nRST,
    input logic                       start,
    input logic                       accept,
    input logic                       value_ready,
    input adder_ctrl_pkg::run_state_e state
);

    // ready is up as soon as reset lets go
    ready_after_reset: assert property (
        @(posedge clk) $rose(nRST) |-> value_ready
    ) else $error("value_ready low in the first cycle after reset");

    // low for the two cycles after accept, idle again from the third sample on
    ready_latency: assert property (
        @(posedge clk) disable iff (!nRST)
        $past(accept, 3) |-> (!$past(value_ready, 2) && !$past(value_ready)
                             && (state == adder_ctrl_pkg::RUN_IDLE))
    ) else $error("value_ready did not return exactly 2 cycles after accept");

    // caller protocol, start only while the unit is idle
    start_when_idle: assert property (
        @(posedge clk) disable iff (!nRST)
        start |-> (state == adder_ctrl_pkg::RUN_IDLE)
    ) else $error("start raised while an operation was in flight");

endmodule

// File: tb/tb_sysarr_adder.sv
`timescale 1ns/1ns

module tb_sysarr_adder;

    localparam int NUM_ROWS    = 14;
    localparam int CYCLE_LIMIT = 8 * NUM_ROWS + 20;

    typedef struct packed {
        logic [15:0]             a;
        logic [15:0]             b;
        adder_ctrl_pkg::add_op_e op;
        logic [15:0]             exp_result;
        logic                    exp_overflow;
    } vector_t;

    logic                    clk;
    logic                    nRST;
    logic                    start;
    adder_ctrl_pkg::add_op_e op;
    fp16_pkg::fp16_t         operand_a;
    fp16_pkg::fp16_t         operand_b;
    logic                    value_ready;
    fp16_pkg::fp16_t         result;
    logic                    overflow;

    vector_t vectors [NUM_ROWS];
    int      cycle_count = 0;

    sysarr_adder u_sysarr_adder (
        .clk         (clk),
        .nRST        (nRST),
        .start       (start),
        .op          (op),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .value_ready (value_ready),
        .result      (result),
        .overflow    (overflow)
    );

    bind sysarr_adder sysarr_adder_checker u_checker (
        .clk         (clk),
        .nRST        (nRST),
        .start       (start),
        .accept      (accept),
        .value_ready (value_ready),
        .state       (state)
    );

    always #50 clk = ~clk;     // 100 ns period

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("test failed");
            $fatal(1, "cycle limit reached");
        end
    end

    // expected values worked out by hand, truncating
    function automatic void load_vectors();
        vectors[0]  = '{16'h3C00, 16'h3C00, adder_ctrl_pkg::OP_ADD, 16'h4000, 1'b0}; // 1+1
        vectors[1]  = '{16'h3E00, 16'h3E00, adder_ctrl_pkg::OP_ADD, 16'h4200, 1'b0}; // 1.5+1.5
        vectors[2]  = '{16'h3C00, 16'h0C00, adder_ctrl_pkg::OP_ADD, 16'h3C00, 1'b0}; // 2^-12 lost
        vectors[3]  = '{16'h4000, 16'h3800, adder_ctrl_pkg::OP_ADD, 16'h4100, 1'b0}; // 2+0.5
        vectors[4]  = '{16'h3C00, 16'h3C00, adder_ctrl_pkg::OP_SUB, 16'h0000, 1'b0};
        vectors[5]  = '{16'h3C00, 16'h3A00, adder_ctrl_pkg::OP_SUB, 16'h3400, 1'b0}; // 1-0.75
        vectors[6]  = '{16'hBC00, 16'h4000, adder_ctrl_pkg::OP_SUB, 16'hC200, 1'b0}; // -1-2
        vectors[7]  = '{16'h7BFF, 16'h7BFF, adder_ctrl_pkg::OP_ADD, 16'h7C00, 1'b1};
        vectors[8]  = '{16'hFBFF, 16'hFBFF, adder_ctrl_pkg::OP_ADD, 16'hFC00, 1'b1};
        vectors[9]  = '{16'h3C00, 16'hBC00, adder_ctrl_pkg::OP_ADD, 16'h0000, 1'b0};
        vectors[10] = '{16'h4000, 16'h3800, adder_ctrl_pkg::OP_SUB, 16'h3E00, 1'b0}; // 2-0.5
        vectors[11] = '{16'h0000, 16'h3C00, adder_ctrl_pkg::OP_ADD, 16'h3C00, 1'b0};
        vectors[12] = '{16'hC000, 16'h3800, adder_ctrl_pkg::OP_ADD, 16'hBE00, 1'b0}; // -2+0.5
        vectors[13] = '{16'h7BFF, 16'hFBFF, adder_ctrl_pkg::OP_SUB, 16'h7C00, 1'b1};
    endfunction

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // outputs must sit still while nothing is in flight
    task automatic idle_cycles(input int gap, input logic [15:0] res, input logic ov);
        for (int k = 0; k < gap; k++) begin
            @(negedge clk);
            check_value("value_ready", {15'b0, value_ready}, 16'h0001);
            check_value("result", result, res);
            check_value("overflow", {15'b0, overflow}, {15'b0, ov});
        end
    endtask

    initial begin
        int          gap;
        int          latency;
        logic [15:0] prev_result;
        logic        prev_overflow;

        void'($urandom(63));
        clk       = 1'b0;
        nRST      = 1'b0;
        start     = 1'b0;
        op        = adder_ctrl_pkg::OP_ADD;
        operand_a = '0;
        operand_b = '0;
        load_vectors();
        prev_result   = 16'h0000;
        prev_overflow = 1'b0;

        repeat (2) @(negedge clk);
        nRST = 1'b1;
        @(negedge clk);
        check_value("value_ready", {15'b0, value_ready}, 16'h0001);
        check_value("result", result, 16'h0000);
        check_value("overflow", {15'b0, overflow}, 16'h0000);

        for (int i = 0; i < NUM_ROWS; i++) begin
            // every third row starts right as ready comes back
            gap = (i % 3 == 2) ? 0 : int'($urandom % 4);
            idle_cycles(gap, prev_result, prev_overflow);

            operand_a = vectors[i].a;
            operand_b = vectors[i].b;
            op        = vectors[i].op;
            start     = 1'b1;
            @(negedge clk);         // accept edge has passed
            start   = 1'b0;
            latency = 0;
            do begin
                @(negedge clk);
                latency++;
            end while (!value_ready);

            check_value("latency", 16'(latency), 16'd2);
            check_value("result", result, vectors[i].exp_result);
            check_value("overflow", {15'b0, overflow}, {15'b0, vectors[i].exp_overflow});
            prev_result   = vectors[i].exp_result;
            prev_overflow = vectors[i].exp_overflow;
        end

        idle_cycles(2, prev_result, prev_overflow);
        $display("test passed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+logic
logic/fp16_pkg.sv
logic/adder_ctrl_pkg.sv
logic/fp16_align.sv
logic/fp16_mantissa_add.sv
logic/fp16_normalize.sv
logic/sysarr_adder.sv
tb/sysarr_adder_checker.sv
tb/tb_sysarr_adder.sv
